/* logic/rv32_defs.svh */
`ifndef RV32_DEFS_SVH
`define RV32_DEFS_SVH

// data word and register index widths
`define RV32_XLEN       32
`define RV32_REG_ADDR_W 5

// major opcodes handled by the datapath
`define RV32_OPCODE_OP     7'b0110011
`define RV32_OPCODE_OP_IMM 7'b0010011
`define RV32_OPCODE_LUI    7'b0110111
`define RV32_OPCODE_AUIPC  7'b0010111

// funct3 of the alu groups
`define RV32_FUNCT3_ADD_SUB 3'b000
`define RV32_FUNCT3_SLL     3'b001
`define RV32_FUNCT3_SLT     3'b010
`define RV32_FUNCT3_SLTU    3'b011
`define RV32_FUNCT3_XOR     3'b100
`define RV32_FUNCT3_SRL_SRA 3'b101
`define RV32_FUNCT3_OR      3'b110
`define RV32_FUNCT3_AND     3'b111

// alt selects sub and sra
`define RV32_FUNCT7_ZERO 7'b0000000
`define RV32_FUNCT7_ALT  7'b0100000

// alu operation codes
`define RV32_ALU_OP_ADD_SUB 4'd0
`define RV32_ALU_OP_SLL     4'd1
`define RV32_ALU_OP_SLT     4'd2
`define RV32_ALU_OP_SLTU    4'd3
`define RV32_ALU_OP_XOR     4'd4
`define RV32_ALU_OP_SRL_SRA 4'd5
`define RV32_ALU_OP_OR      4'd6
`define RV32_ALU_OP_AND     4'd7
// passes operand 2 through, used by lui
`define RV32_ALU_OP_SRC2    4'd8

`endif

/* logic/rv32_pkg.sv */
`default_nettype none

`include "rv32_defs.svh"

package rv32_pkg;

    // one data word or a program counter
    typedef logic [`RV32_XLEN-1:0] word_t;

    typedef logic [`RV32_REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [3:0] alu_op_t;

    // instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    typedef logic [4:0] shamt_t;

endpackage

`default_nettype wire

/* logic/rv32_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// register file read ports, answered combinationally
interface rf_read_if;
    rv32_pkg::reg_addr_t rs1_addr;
    rv32_pkg::reg_addr_t rs2_addr;
    rv32_pkg::word_t     rs1_value;
    rv32_pkg::word_t     rs2_value;

    modport decode_mp (output rs1_addr, output rs2_addr, input rs1_value, input rs2_value);
    modport rf_mp (input rs1_addr, input rs2_addr, output rs1_value, output rs2_value);
endinterface

// decode stage register to execute
interface exec_if;
    logic                valid;
    logic                illegal;
    rv32_pkg::alu_op_t   alu_op;
    logic                alt;
    logic                src1_pc;
    logic                src2_imm;
    logic                writeback;
    rv32_pkg::reg_addr_t rd;
    rv32_pkg::word_t     pc;
    rv32_pkg::word_t     imm;
    rv32_pkg::word_t     rs1_value;
    rv32_pkg::word_t     rs2_value;

    modport decode_mp (
        output valid, illegal, alu_op, alt, src1_pc, src2_imm, writeback,
        output rd, pc, imm, rs1_value, rs2_value
    );
    modport exec_mp (
        input valid, illegal, alu_op, alt, src1_pc, src2_imm, writeback,
        input rd, pc, imm, rs1_value, rs2_value
    );
endinterface

// execute stage register to the result stage
interface wb_if;
    logic                valid;
    logic                illegal;
    logic                writeback;
    rv32_pkg::reg_addr_t rd;
    rv32_pkg::word_t     value;

    modport exec_mp (output valid, illegal, writeback, rd, value);
    modport result_mp (input valid, illegal, writeback, rd, value);
endinterface

`default_nettype wire

/* logic/rv32_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32_defs.svh"

module rv32_decode (
    input  wire logic            clk,
    input  wire logic            reset_i,
    input  wire logic            instr_valid_i,
    input  wire rv32_pkg::word_t instr_i,
    input  wire rv32_pkg::word_t pc_i,
    rf_read_if.decode_mp         rf,
    exec_if.decode_mp            ex
);
    rv32_pkg::opcode_t   opcode;
    rv32_pkg::funct3_t   funct3;
    rv32_pkg::funct7_t   funct7;
    rv32_pkg::reg_addr_t rd;
    rv32_pkg::shamt_t    shamt;
    rv32_pkg::word_t     imm_i;
    rv32_pkg::word_t     imm_u;
    rv32_pkg::alu_op_t   funct3_op;

    logic                d_legal;
    logic                d_alt;
    logic                d_src1_pc;
    logic                d_src2_imm;
    rv32_pkg::alu_op_t   d_alu_op;
    rv32_pkg::word_t     d_imm;

    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign shamt  = instr_i[24:20];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {instr_i[31:12], 12'b0};

    assign rf.rs1_addr = instr_i[19:15];
    assign rf.rs2_addr = instr_i[24:20];

    // alu code shared by the register and immediate groups
    always_comb begin
        funct3_op = `RV32_ALU_OP_ADD_SUB;
        case (funct3)
            `RV32_FUNCT3_ADD_SUB: funct3_op = `RV32_ALU_OP_ADD_SUB;
            `RV32_FUNCT3_SLL:     funct3_op = `RV32_ALU_OP_SLL;
            `RV32_FUNCT3_SLT:     funct3_op = `RV32_ALU_OP_SLT;
            `RV32_FUNCT3_SLTU:    funct3_op = `RV32_ALU_OP_SLTU;
            `RV32_FUNCT3_XOR:     funct3_op = `RV32_ALU_OP_XOR;
            `RV32_FUNCT3_SRL_SRA: funct3_op = `RV32_ALU_OP_SRL_SRA;
            `RV32_FUNCT3_OR:      funct3_op = `RV32_ALU_OP_OR;
            `RV32_FUNCT3_AND:     funct3_op = `RV32_ALU_OP_AND;
        endcase
    end

    always_comb begin
        d_legal    = 1'b0;
        d_alu_op   = `RV32_ALU_OP_ADD_SUB;
        d_alt      = 1'b0;
        d_src1_pc  = 1'b0;
        d_src2_imm = 1'b0;
        d_imm      = '0;
        case (opcode)
            `RV32_OPCODE_LUI: begin
                d_legal    = 1'b1;
                d_alu_op   = `RV32_ALU_OP_SRC2;
                d_src2_imm = 1'b1;
                d_imm      = imm_u;
            end
            `RV32_OPCODE_AUIPC: begin
                d_legal    = 1'b1;
                d_src1_pc  = 1'b1;
                d_src2_imm = 1'b1;
                d_imm      = imm_u;
            end
            `RV32_OPCODE_OP_IMM: begin
                d_legal    = 1'b1;
                d_alu_op   = funct3_op;
                d_src2_imm = 1'b1;
                d_imm      = imm_i;
                // shifts take a zero-extended shamt and constrain funct7
                if (funct3 == `RV32_FUNCT3_SLL) begin
                    d_imm   = rv32_pkg::word_t'(shamt);
                    d_legal = (funct7 == `RV32_FUNCT7_ZERO);
                end else if (funct3 == `RV32_FUNCT3_SRL_SRA) begin
                    d_imm   = rv32_pkg::word_t'(shamt);
                    d_alt   = (funct7 == `RV32_FUNCT7_ALT);
                    d_legal = (funct7 == `RV32_FUNCT7_ZERO) || (funct7 == `RV32_FUNCT7_ALT);
                end
            end
            `RV32_OPCODE_OP: begin
                d_alu_op = funct3_op;
                d_alt    = (funct7 == `RV32_FUNCT7_ALT);
                // alt only exists for sub and sra
                d_legal  = (funct7 == `RV32_FUNCT7_ZERO) ||
                           ((funct7 == `RV32_FUNCT7_ALT) &&
                            ((funct3 == `RV32_FUNCT3_ADD_SUB) ||
                             (funct3 == `RV32_FUNCT3_SRL_SRA)));
            end
            default: begin
                d_legal = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex.valid     <= 1'b0;
            ex.illegal   <= 1'b0;
            ex.writeback <= 1'b0;
            ex.alu_op    <= '0;
            ex.alt       <= 1'b0;
            ex.src1_pc   <= 1'b0;
            ex.src2_imm  <= 1'b0;
            ex.rd        <= '0;
            ex.pc        <= '0;
            ex.imm       <= '0;
            ex.rs1_value <= '0;
            ex.rs2_value <= '0;
        end else begin
            ex.valid     <= instr_valid_i;
            ex.illegal   <= instr_valid_i & ~d_legal;
            // every kept instruction writes a register
            ex.writeback <= instr_valid_i & d_legal;
            ex.alu_op    <= d_alu_op;
            ex.alt       <= d_alt;
            ex.src1_pc   <= d_src1_pc;
            ex.src2_imm  <= d_src2_imm;
            ex.rd        <= rd;
            ex.pc        <= pc_i;
            ex.imm       <= d_imm;
            ex.rs1_value <= rf.rs1_value;
            ex.rs2_value <= rf.rs2_value;
        end
    end

endmodule

`default_nettype wire

/* logic/rv32_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32_defs.svh"

module rv32_execute (
    input  wire logic clk,
    input  wire logic reset_i,
    exec_if.exec_mp   ex,
    wb_if.exec_mp     wb
);
    rv32_pkg::word_t  op1;
    rv32_pkg::word_t  op2;
    rv32_pkg::shamt_t shamt;
    rv32_pkg::word_t  alu_result;

    assign op1   = ex.src1_pc ? ex.pc : ex.rs1_value;
    assign op2   = ex.src2_imm ? ex.imm : ex.rs2_value;
    assign shamt = op2[4:0];

    always_comb begin
        case (ex.alu_op)
            `RV32_ALU_OP_ADD_SUB: alu_result = ex.alt ? (op1 - op2) : (op1 + op2);
            `RV32_ALU_OP_SLL:     alu_result = op1 << shamt;
            `RV32_ALU_OP_SLT:     alu_result = rv32_pkg::word_t'($signed(op1) < $signed(op2));
            `RV32_ALU_OP_SLTU:    alu_result = rv32_pkg::word_t'(op1 < op2);
            `RV32_ALU_OP_XOR:     alu_result = op1 ^ op2;
            `RV32_ALU_OP_SRL_SRA: begin
                if (ex.alt) begin
                    alu_result = rv32_pkg::word_t'($signed(op1) >>> shamt);
                end else begin
                    alu_result = op1 >> shamt;
                end
            end
            `RV32_ALU_OP_OR:      alu_result = op1 | op2;
            `RV32_ALU_OP_AND:     alu_result = op1 & op2;
            `RV32_ALU_OP_SRC2:    alu_result = op2;
            default:              alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb.valid     <= 1'b0;
            wb.illegal   <= 1'b0;
            wb.writeback <= 1'b0;
            wb.rd        <= '0;
            wb.value     <= '0;
        end else begin
            wb.valid     <= ex.valid;
            wb.illegal   <= ex.illegal;
            wb.writeback <= ex.writeback;
            wb.rd        <= ex.rd;
            wb.value     <= alu_result;
        end
    end

endmodule

`default_nettype wire

/* logic/rv32_result.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_result (
    input  wire logic           clk,
    input  wire logic           reset_i,
    rf_read_if.rf_mp            rf,
    wb_if.result_mp             wb,
    output logic                result_valid_o,
    output logic                result_illegal_o,
    output rv32_pkg::reg_addr_t result_rd_o,
    output rv32_pkg::word_t     result_value_o
);
    // x0 has no storage
    rv32_pkg::word_t regs [1:31];
    logic            write_en;

    assign write_en = wb.valid & ~wb.illegal & wb.writeback & (wb.rd != '0);

    // write-through so a reader two issues behind sees the value
    function automatic rv32_pkg::word_t read_reg(input rv32_pkg::reg_addr_t addr);
        rv32_pkg::word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (write_en && (addr == wb.rd)) begin
            value = wb.value;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    // reads follow the stored registers and the write port, not only the addresses
    always_comb begin
        rf.rs1_value = read_reg(rf.rs1_addr);
        rf.rs2_value = read_reg(rf.rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
            result_valid_o   <= 1'b0;
            result_illegal_o <= 1'b0;
            result_rd_o      <= '0;
            result_value_o   <= '0;
        end else begin
            if (write_en) begin
                regs[wb.rd] <= wb.value;
            end
            // writes to x0 are still reported
            result_valid_o   <= wb.valid;
            result_illegal_o <= wb.illegal;
            result_rd_o      <= wb.rd;
            result_value_o   <= wb.value;
        end
    end

endmodule

`default_nettype wire

/* logic/rv32_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32_defs.svh"

module rv32_core (
    input  wire logic                        clk,
    input  wire logic                        reset_i,
    input  wire logic                        instr_valid_i,
    input  wire logic [`RV32_XLEN-1:0]       instr_i,
    input  wire logic [`RV32_XLEN-1:0]       pc_i,
    output logic                             result_valid_o,
    output logic                             result_illegal_o,
    output logic [`RV32_REG_ADDR_W-1:0]      result_rd_o,
    output logic [`RV32_XLEN-1:0]            result_value_o
);
    rf_read_if rf_bus ();
    exec_if    exec_bus ();
    wb_if      wb_bus ();

    // decode also drives the register file read addresses
    rv32_decode u_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rf            (rf_bus.decode_mp),
        .ex            (exec_bus.decode_mp)
    );

    rv32_execute u_execute (
        .clk     (clk),
        .reset_i (reset_i),
        .ex      (exec_bus.exec_mp),
        .wb      (wb_bus.exec_mp)
    );

    // owns the register file
    rv32_result u_result (
        .clk              (clk),
        .reset_i          (reset_i),
        .rf               (rf_bus.rf_mp),
        .wb               (wb_bus.result_mp),
        .result_valid_o   (result_valid_o),
        .result_illegal_o (result_illegal_o),
        .result_rd_o      (result_rd_o),
        .result_value_o   (result_value_o)
    );

endmodule

`default_nettype wire

/* sim/rv32_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32_defs.svh"

module rv32_core_tb;
    // about four times the length of all tests together
    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        reset_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic        result_valid_o;
    logic        result_illegal_o;
    logic [4:0]  result_rd_o;
    logic [31:0] result_value_o;

    logic [31:0] lfsr_state = 32'h72c9;
    int          err_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    logic [31:0] q_instr [$];
    logic [31:0] q_pc [$];
    logic [31:0] q_value [$];
    logic        q_illegal [$];

    rv32_core DUT (
        .clk              (clk),
        .reset_i          (reset_i),
        .instr_valid_i    (instr_valid_i),
        .instr_i          (instr_i),
        .pc_i             (pc_i),
        .result_valid_o   (result_valid_o),
        .result_illegal_o (result_illegal_o),
        .result_rd_o      (result_rd_o),
        .result_value_o   (result_value_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV32_OPCODE_OP};
    endfunction

    // expected alu result straight from the rv32i definitions
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] s;
        s = b[4:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << s;
            // signs differ means the negative one is smaller
            3'd2: return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? ((a >> s) | ({32{a[31]}} << (6'd32 - s))) : (a >> s);
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, actual, expected);
            err_count++;
        end
    endtask

    // issue the queued instructions on consecutive cycles, results come three edges later
    task automatic run_seq();
        int n;
        n = q_instr.size();
        q_value.delete();
        q_illegal.delete();
        for (int t = 0; t < n + 3; t++) begin
            @(negedge clk);
            if (t >= 3) begin
                check_eq("result_valid_o", result_valid_o, 1);
                check_eq("result_rd_o", result_rd_o, q_instr[t-3][11:7]);
                q_value.push_back(result_value_o);
                q_illegal.push_back(result_illegal_o);
            end
            instr_valid_i = (t < n);
            instr_i       = (t < n) ? q_instr[t] : '0;
            pc_i          = (t < n) ? q_pc[t] : '0;
        end
        @(negedge clk);
        check_eq("result_valid_o", result_valid_o, 0);
    endtask

    task automatic exec_check(input logic [31:0] instr, input logic [31:0] pc,
                              input logic exp_illegal, input logic [31:0] exp_value);
        q_instr = {instr};
        q_pc    = {pc};
        run_seq();
        check_eq("result_illegal_o", q_illegal[0], exp_illegal);
        if (!exp_illegal) begin
            check_eq("result_value_o", q_value[0], exp_value);
        end
    endtask

    // lui then addi, the upper part rounded for the signed low part
    task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
        logic [19:0] hi;
        hi = (value + 32'h800) >> 12;
        exec_check({hi, rd, `RV32_OPCODE_LUI}, 0, 1'b0, {hi, 12'h0});
        exec_check(enc_i(value[11:0], rd, 3'd0, rd, `RV32_OPCODE_OP_IMM), 0, 1'b0, value);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("%s: ok", name);
            tests_passed++;
        end else begin
            $display("%s: %0d errors", name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    task automatic reset_state();
        int errs;
        errs = err_count;
        @(negedge clk);
        check_eq("result_valid_o", result_valid_o, 0);
        check_eq("result_illegal_o", result_illegal_o, 0);
        exec_check(enc_r(`RV32_FUNCT7_ZERO, 5'd2, 5'd1, 3'd0, 5'd5), 0, 1'b0, 0);
        finish_test("reset_state", errs);
    endtask

    task automatic imm_ops();
        int errs;
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        errs = err_count;
        for (int i = 0; i < 9; i++) begin
            f3  = (i == 8) ? 3'd5 : 3'(i);
            alt = (i == 8);
            a   = rand_bits(32);
            set_reg(5'd6, a);
            if (f3 == 3'd1 || f3 == 3'd5) begin
                b   = rand_bits(5);
                imm = {alt ? `RV32_FUNCT7_ALT : `RV32_FUNCT7_ZERO, b[4:0]};
            end else begin
                imm = rand_bits(12);
                b   = {{20{imm[11]}}, imm};
            end
            exec_check(enc_i(imm, 5'd6, f3, 5'd7, `RV32_OPCODE_OP_IMM), 0, 1'b0,
                       ref_alu(f3, alt, a, b));
        end
        finish_test("imm_ops", errs);
    endtask

    task automatic reg_ops();
        int errs;
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] a;
        logic [31:0] b;
        errs = err_count;
        for (int i = 0; i < 10; i++) begin
            f3  = (i < 8) ? 3'(i) : ((i == 8) ? 3'd0 : 3'd5);
            alt = (i >= 8);
            a   = rand_bits(32);
            b   = rand_bits(32);
            // negative rs1 against positive rs2 for the compares and shifts
            if (f3 == 3'd2 || f3 == 3'd3 || f3 == 3'd5) begin
                a[31] = 1'b1;
                b[31] = 1'b0;
            end
            set_reg(5'd8, a);
            set_reg(5'd9, b);
            exec_check(enc_r(alt ? `RV32_FUNCT7_ALT : `RV32_FUNCT7_ZERO, 5'd9, 5'd8, f3, 5'd10),
                       0, 1'b0, ref_alu(f3, alt, a, b));
        end
        finish_test("reg_ops", errs);
    endtask

    task automatic upper_imm();
        int errs;
        logic [19:0] hi;
        logic [31:0] pc;
        errs = err_count;
        for (int i = 0; i < 2; i++) begin
            hi = rand_bits(20);
            pc = rand_bits(32);
            exec_check({hi, 5'd10, `RV32_OPCODE_LUI}, 0, 1'b0, {hi, 12'h0});
            exec_check({hi, 5'd11, `RV32_OPCODE_AUIPC}, pc, 1'b0, pc + {hi, 12'h0});
        end
        finish_test("upper_imm", errs);
    endtask

    task automatic x0_and_illegal();
        int errs;
        errs = err_count;
        exec_check(enc_i(12'd5, 5'd0, 3'd0, 5'd0, `RV32_OPCODE_OP_IMM), 0, 1'b0, 5);
        exec_check(enc_r(`RV32_FUNCT7_ZERO, 5'd0, 5'd0, 3'd0, 5'd12), 0, 1'b0, 0);
        set_reg(5'd13, 32'h1234_5678);
        // lw x13, 0(x0)
        exec_check(enc_i(12'd0, 5'd0, 3'd2, 5'd13, 7'b0000011), 0, 1'b1, 0);
        exec_check(enc_i(12'd0, 5'd13, 3'd0, 5'd14, `RV32_OPCODE_OP_IMM), 0, 1'b0, 32'h1234_5678);
        exec_check(enc_r(7'h01, 5'd0, 5'd0, 3'd0, 5'd13), 0, 1'b1, 0);
        exec_check(enc_i(12'd0, 5'd13, 3'd0, 5'd14, `RV32_OPCODE_OP_IMM), 0, 1'b0, 32'h1234_5678);
        finish_test("x0_and_illegal", errs);
    endtask

    task automatic hazards();
        int errs;
        errs = err_count;
        q_instr = {enc_i(12'd7, 5'd0, 3'd0, 5'd3, `RV32_OPCODE_OP_IMM),
                   enc_i(12'd0, 5'd3, 3'd0, 5'd4, `RV32_OPCODE_OP_IMM)};
        q_pc    = {32'h0, 32'h0};
        run_seq();
        check_eq("result_value_o", q_value[1], 0);
        exec_check(enc_i(12'd0, 5'd0, 3'd0, 5'd3, `RV32_OPCODE_OP_IMM), 0, 1'b0, 0);
        // one nop between writer and reader
        q_instr = {enc_i(12'd7, 5'd0, 3'd0, 5'd3, `RV32_OPCODE_OP_IMM),
                   enc_i(12'd0, 5'd0, 3'd0, 5'd0, `RV32_OPCODE_OP_IMM),
                   enc_i(12'd0, 5'd3, 3'd0, 5'd4, `RV32_OPCODE_OP_IMM)};
        q_pc    = {32'h0, 32'h0, 32'h0};
        run_seq();
        check_eq("result_value_o", q_value[2], 7);
        q_instr = {enc_i(12'd1, 5'd0, 3'd0, 5'd15, `RV32_OPCODE_OP_IMM),
                   enc_i(12'd2, 5'd0, 3'd0, 5'd16, `RV32_OPCODE_OP_IMM),
                   enc_i(12'd3, 5'd0, 3'd0, 5'd17, `RV32_OPCODE_OP_IMM)};
        run_seq();
        for (int i = 0; i < 3; i++) begin
            check_eq("result_value_o", q_value[i], i + 1);
        end
        finish_test("hazards", errs);
    endtask

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles without finishing the tests", cycle_count);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        repeat (10) begin
            @(negedge clk);
            check_eq("result_valid_o", result_valid_o, 0);
            check_eq("result_illegal_o", result_illegal_o, 0);
        end
        reset_i = 1'b0;
        reset_state();
        imm_ops();
        reg_ops();
        upper_imm();
        x0_and_illegal();
        hazards();
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* Bender.yml */
package:
  name: rv32_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv32_pkg.sv
      - logic/rv32_ifs.sv
      - logic/rv32_decode.sv
      - logic/rv32_execute.sv
      - logic/rv32_result.sv
      - logic/rv32_core.sv
      - target: test
        files:
          - sim/rv32_core_tb.sv

/* vlog.f */
+incdir+logic
logic/rv32_pkg.sv
logic/rv32_ifs.sv
logic/rv32_decode.sv
logic/rv32_execute.sv
logic/rv32_result.sv
logic/rv32_core.sv
sim/rv32_core_tb.sv
